//--- elink_params.svh
`ifndef ELINK_PARAMS_SVH
`define ELINK_PARAMS_SVH

// Payload and line widths
`define ELINK_BYTE_W 8
`define ELINK_CODE_W 10
`define ELINK_LANE_W 2
`define ELINK_PAIRS 5   // Lane pairs per code

// Comma bits abcdeif, held as code[6:0] with code[0] = a (first bit on the line)
`define ELINK_COMMA_N 7'b1111100   // 0011111, K28.x sent at RD-
`define ELINK_COMMA_P 7'b0000011   // 1100000, K28.x sent at RD+

// Delimiter codes at RD-, written abcdeifghj with a as MSB
// RD+ form is the complement for all three
`define ELINK_K28_1 10'b0011111001   // Start of packet
`define ELINK_K28_5 10'b0011111010   // Idle comma
`define ELINK_K28_6 10'b0011110110   // End of packet

`endif

//--- elinkPkg.sv
`default_nettype none
`include "elink_params.svh"

package elinkPkg;

  // Same split as the 2-bit delimiter beside the byte
  typedef enum logic [1:0]
  {
    kindData = 2'b00,
    kindEop  = 2'b01,   // K28.6
    kindSop  = 2'b10,   // K28.1
    kindIdle = 2'b11    // K28.5
  } symKind_t;

  // One payload symbol, delimiter on top of the byte
  typedef struct packed
  {
    symKind_t                kind;
    logic [`ELINK_BYTE_W-1:0] dataByte;
  } elinkSym_t;

  // Line code plus running disparity after it
  typedef struct packed
  {
    logic [`ELINK_CODE_W-1:0] code;   // code[0] = a, sent first
    logic                     rdPos;  // 1 = positive
  } elinkCode_t;

  typedef struct packed
  {
    logic aligned;
    logic codeErr;
    logic dispErr;
  } elinkRxStat_t;

  // Flip code bit order, a at MSB <-> a at LSB
  function automatic logic [`ELINK_CODE_W-1:0] revCode(input logic [`ELINK_CODE_W-1:0] c);
    for (int i = 0; i < `ELINK_CODE_W; i++)
      revCode[i] = c[`ELINK_CODE_W-1-i];
  endfunction

endpackage

`default_nettype wire

//--- elinkEncoder8b10b.sv
`timescale 1ns/1ps
`default_nettype none
`include "elink_params.svh"

module elinkEncoder8b10b
  import elinkPkg::*;
(
  input  wire logic      getDataTrig,
  input  wire logic      rstN,
  input  wire logic      symReq,   // Last pair of the current code
  input  wire elinkSym_t dataIn,
  input  wire logic      dataRdy,
  output elinkCode_t     txCode
);

  // 5b/6b table, RD- form abcdei with a as MSB
  function automatic logic [5:0] tab6(input logic [4:0] x);
    case (x)
      5'd0:  tab6 = 6'b100111;
      5'd1:  tab6 = 6'b011101;
      5'd2:  tab6 = 6'b101101;
      5'd3:  tab6 = 6'b110001;
      5'd4:  tab6 = 6'b110101;
      5'd5:  tab6 = 6'b101001;
      5'd6:  tab6 = 6'b011001;
      5'd7:  tab6 = 6'b111000;   // Balanced, still alternates
      5'd8:  tab6 = 6'b111001;
      5'd9:  tab6 = 6'b100101;
      5'd10: tab6 = 6'b010101;
      5'd11: tab6 = 6'b110100;
      5'd12: tab6 = 6'b001101;
      5'd13: tab6 = 6'b101100;
      5'd14: tab6 = 6'b011100;
      5'd15: tab6 = 6'b010111;
      5'd16: tab6 = 6'b011011;
      5'd17: tab6 = 6'b100011;
      5'd18: tab6 = 6'b010011;
      5'd19: tab6 = 6'b110010;
      5'd20: tab6 = 6'b001011;
      5'd21: tab6 = 6'b101010;
      5'd22: tab6 = 6'b011010;
      5'd23: tab6 = 6'b111010;
      5'd24: tab6 = 6'b110011;
      5'd25: tab6 = 6'b100110;
      5'd26: tab6 = 6'b010110;
      5'd27: tab6 = 6'b110110;
      5'd28: tab6 = 6'b001110;
      5'd29: tab6 = 6'b101110;
      5'd30: tab6 = 6'b011110;
      default: tab6 = 6'b101011;   // D.31
    endcase
  endfunction

  // 3b/4b table, RD- form fghj, primary D.x.7
  function automatic logic [3:0] tab4(input logic [2:0] y);
    case (y)
      3'd0: tab4 = 4'b1011;
      3'd1: tab4 = 4'b1001;
      3'd2: tab4 = 4'b0101;
      3'd3: tab4 = 4'b1100;
      3'd4: tab4 = 4'b1101;
      3'd5: tab4 = 4'b1010;
      3'd6: tab4 = 4'b0110;
      default: tab4 = 4'b1110;
    endcase
  endfunction

  elinkSym_t  symSel;
  logic [4:0] x5;
  logic [2:0] y3;
  logic [5:0] w6;
  logic [3:0] w4;
  logic [9:0] kCode;
  logic [9:0] wAll;   // abcdeifghj, a as MSB
  logic       alt7;
  logic       rdMid;
  logic       rdOut;

  always_comb
  begin
    symSel = dataRdy ? dataIn : '{kind: kindIdle, dataByte: 8'hBC};   // No symbol, send comma
    x5 = symSel.dataByte[4:0];
    y3 = symSel.dataByte[7:5];

    // Data path, 6b sub-block first
    w6 = tab6(x5);
    if (txCode.rdPos && (($countones(w6) != 3) || (x5 == 5'd7)))
      w6 = ~w6;
    rdMid = ($countones(w6) != 3) ? !txCode.rdPos : txCode.rdPos;

    // Alternate D.x.7 avoids a run of five
    alt7 = (y3 == 3'd7) &&
           ((!rdMid && ((x5 == 5'd17) || (x5 == 5'd18) || (x5 == 5'd20))) ||
            (rdMid && ((x5 == 5'd11) || (x5 == 5'd13) || (x5 == 5'd14))));
    w4 = alt7 ? 4'b0111 : tab4(y3);
    if (rdMid && (($countones(w4) != 2) || (y3 == 3'd3)))
      w4 = ~w4;
    rdOut = ($countones(w4) != 2) ? !rdMid : rdMid;
    wAll = {w6, w4};

    // Delimiters override, all flip disparity
    case (symSel.kind)
      kindSop: kCode = `ELINK_K28_1;
      kindEop: kCode = `ELINK_K28_6;
      default: kCode = `ELINK_K28_5;
    endcase
    if (symSel.kind != kindData)
    begin
      wAll = txCode.rdPos ? ~kCode : kCode;
      rdOut = !txCode.rdPos;
    end
  end

  // Reset code is the first idle, sent from RD-
  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      txCode.code <= revCode(`ELINK_K28_5);
      txCode.rdPos <= 1'b1;
    end
    else if (symReq)
    begin
      txCode.code <= revCode(wAll);   // a to bit 0 for the serializer
      txCode.rdPos <= rdOut;
    end
  end

endmodule

`default_nettype wire

//--- elinkTxSerializer.sv
`timescale 1ns/1ps
`default_nettype none
`include "elink_params.svh"

module elinkTxSerializer
  import elinkPkg::*;
(
  input  wire logic                     getDataTrig,
  input  wire logic                     rstN,
  input  wire elinkCode_t               txCode,
  input  wire logic                     swapBits,
  input  wire logic                     reverseOrder,   // MSB first
  output logic                          symReq,
  output logic [`ELINK_LANE_W-1:0]      elinkOut
);

  logic [2:0]                           pairCnt;
  logic [`ELINK_CODE_W-1:0]             ordered;
  logic [`ELINK_CODE_W-`ELINK_LANE_W-1:0] shReg;   // Pairs still to go
  logic [`ELINK_LANE_W-1:0]             pairNow;

  // Bit order picked once per code
  assign ordered = reverseOrder ? revCode(txCode.code) : txCode.code;

  // First pair straight from the encoder register
  assign pairNow = (pairCnt == 3'd0) ? ordered[`ELINK_LANE_W-1:0] :
                                       shReg[`ELINK_LANE_W-1:0];

  assign elinkOut = swapBits ? {pairNow[0], pairNow[1]} : pairNow;

  assign symReq = (pairCnt == 3'(`ELINK_PAIRS - 1));   // Encoder loads on the last pair

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
      pairCnt <= '0;
    else if (symReq)
      pairCnt <= '0;
    else
      pairCnt <= pairCnt + 3'd1;
  end

  always_ff @(posedge getDataTrig)
  begin
    if (pairCnt == 3'd0)
      shReg <= ordered[`ELINK_CODE_W-1:`ELINK_LANE_W];   // Rest of the new code
    else
      shReg <= shReg >> `ELINK_LANE_W;
  end

endmodule

`default_nettype wire

//--- elinkRxAligner.sv
`timescale 1ns/1ps
`default_nettype none
`include "elink_params.svh"

module elinkRxAligner
  import elinkPkg::*;
(
  input  wire logic                    getDataTrig,
  input  wire logic                    rstN,
  input  wire logic [`ELINK_LANE_W-1:0] elinkIn,
  input  wire logic                    swapBits,
  input  wire logic                    reverseOrder,
  output logic [`ELINK_CODE_W-1:0]     rxCode,
  output logic                         codeStrobe,
  output logic                         aligned,
  input  wire logic                    realignHint   // Decoder code error
);

  logic [2*`ELINK_CODE_W-1:0] win;   // Oldest bit at 0
  logic [`ELINK_LANE_W-1:0]   pairIn;
  logic [`ELINK_CODE_W-1:0]   candCode [`ELINK_CODE_W];
  logic [`ELINK_CODE_W-1:0]   commaAt;
  logic                       anyComma;
  logic [3:0]                 firstOff;
  logic [3:0]                 phase;
  logic [2:0]                 tickCnt;
  logic                       codeTick;
  logic                       pending;      // Candidate phase waiting for second comma
  logic                       commaSeen;
  logic                       strobeDly;    // Decoder status valid
  logic [1:0]                 missCnt;

  assign pairIn = swapBits ? {elinkIn[0], elinkIn[1]} : elinkIn;
  assign codeTick = (tickCnt == 3'd0);

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
      win <= '0;
    else
      win <= {pairIn, win[2*`ELINK_CODE_W-1:`ELINK_LANE_W]};
  end

  // Try every offset, lowest comma wins
  always_comb
  begin
    logic [`ELINK_CODE_W-1:0] rawCode;
    anyComma = 1'b0;
    firstOff = '0;
    for (int o = `ELINK_CODE_W - 1; o >= 0; o--)
    begin
      rawCode = win[o +: `ELINK_CODE_W];
      candCode[o] = reverseOrder ? revCode(rawCode) : rawCode;
      commaAt[o] = (candCode[o][6:0] == `ELINK_COMMA_N) ||
                   (candCode[o][6:0] == `ELINK_COMMA_P);
      if (commaAt[o])
      begin
        anyComma = 1'b1;
        firstOff = 4'(o);
      end
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      aligned <= 1'b0;
      pending <= 1'b0;
      phase <= '0;
      tickCnt <= '0;
      missCnt <= '0;
      commaSeen <= 1'b0;
      codeStrobe <= 1'b0;
      strobeDly <= 1'b0;
    end
    else
    begin
      codeStrobe <= 1'b0;
      strobeDly <= codeStrobe;
      tickCnt <= (tickCnt == 3'(`ELINK_PAIRS - 1)) ? 3'd0 : tickCnt + 3'd1;
      if (!aligned)
      begin
        if (!pending && anyComma)
        begin
          phase <= firstOff;   // Same offset recurs five clocks on
          pending <= 1'b1;
          tickCnt <= 3'd1;
        end
        else if (pending && codeTick)
        begin
          pending <= 1'b0;
          aligned <= commaAt[phase];
          missCnt <= '0;
        end
      end
      else
      begin
        if (codeTick)
        begin
          codeStrobe <= 1'b1;
          commaSeen <= commaAt[phase];
        end
        // Bad code with no comma counts toward lock loss
        if (strobeDly)
        begin
          if (realignHint && !commaSeen)
          begin
            missCnt <= missCnt + 2'd1;
            if (missCnt == 2'd2)
            begin
              aligned <= 1'b0;
              missCnt <= '0;
            end
          end
          else
            missCnt <= '0;
        end
      end
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (aligned && codeTick)
      rxCode <= candCode[phase];
  end

endmodule

`default_nettype wire

//--- elinkDecoder8b10b.sv
`timescale 1ns/1ps
`default_nettype none
`include "elink_params.svh"

module elinkDecoder8b10b
  import elinkPkg::*;
(
  input  wire logic                    getDataTrig,
  input  wire logic                    rstN,
  input  wire logic [`ELINK_CODE_W-1:0] rxCode,
  input  wire logic                    codeStrobe,
  output elinkSym_t                    rxSym,
  output logic                         rxValid,
  output logic                         codeErr,
  output logic                         dispErr
);

  // 6b/5b, both disparity forms, MSB is the valid flag
  function automatic logic [5:0] dec6(input logic [5:0] w);
    case (w)
      6'b100111, 6'b011000: dec6 = {1'b1, 5'd0};
      6'b011101, 6'b100010: dec6 = {1'b1, 5'd1};
      6'b101101, 6'b010010: dec6 = {1'b1, 5'd2};
      6'b110001:            dec6 = {1'b1, 5'd3};
      6'b110101, 6'b001010: dec6 = {1'b1, 5'd4};
      6'b101001:            dec6 = {1'b1, 5'd5};
      6'b011001:            dec6 = {1'b1, 5'd6};
      6'b111000, 6'b000111: dec6 = {1'b1, 5'd7};
      6'b111001, 6'b000110: dec6 = {1'b1, 5'd8};
      6'b100101:            dec6 = {1'b1, 5'd9};
      6'b010101:            dec6 = {1'b1, 5'd10};
      6'b110100:            dec6 = {1'b1, 5'd11};
      6'b001101:            dec6 = {1'b1, 5'd12};
      6'b101100:            dec6 = {1'b1, 5'd13};
      6'b011100:            dec6 = {1'b1, 5'd14};
      6'b010111, 6'b101000: dec6 = {1'b1, 5'd15};
      6'b011011, 6'b100100: dec6 = {1'b1, 5'd16};
      6'b100011:            dec6 = {1'b1, 5'd17};
      6'b010011:            dec6 = {1'b1, 5'd18};
      6'b110010:            dec6 = {1'b1, 5'd19};
      6'b001011:            dec6 = {1'b1, 5'd20};
      6'b101010:            dec6 = {1'b1, 5'd21};
      6'b011010:            dec6 = {1'b1, 5'd22};
      6'b111010, 6'b000101: dec6 = {1'b1, 5'd23};
      6'b110011, 6'b001100: dec6 = {1'b1, 5'd24};
      6'b100110:            dec6 = {1'b1, 5'd25};
      6'b010110:            dec6 = {1'b1, 5'd26};
      6'b110110, 6'b001001: dec6 = {1'b1, 5'd27};
      6'b001110, 6'b001111, 6'b110000: dec6 = {1'b1, 5'd28};   // D.28 and K.28
      6'b101110, 6'b010001: dec6 = {1'b1, 5'd29};
      6'b011110, 6'b100001: dec6 = {1'b1, 5'd30};
      6'b101011, 6'b010100: dec6 = {1'b1, 5'd31};
      default:              dec6 = {1'b0, 5'd0};
    endcase
  endfunction

  // 4b/3b, primary and alternate D.x.7 both accepted
  function automatic logic [3:0] dec4(input logic [3:0] w);
    case (w)
      4'b1011, 4'b0100: dec4 = {1'b1, 3'd0};
      4'b1001:          dec4 = {1'b1, 3'd1};
      4'b0101:          dec4 = {1'b1, 3'd2};
      4'b1100, 4'b0011: dec4 = {1'b1, 3'd3};
      4'b1101, 4'b0010: dec4 = {1'b1, 3'd4};
      4'b1010:          dec4 = {1'b1, 3'd5};
      4'b0110:          dec4 = {1'b1, 3'd6};
      4'b1110, 4'b0001, 4'b0111, 4'b1000: dec4 = {1'b1, 3'd7};
      default:          dec4 = {1'b0, 3'd0};
    endcase
  endfunction

  logic [9:0] wAll;   // abcdeifghj, a as MSB
  logic [5:0] w6;
  logic [3:0] w4;
  logic       ok6;
  logic       ok4;
  logic [4:0] x5;
  logic [2:0] y3;
  logic       isK;
  logic       kKnown;
  symKind_t   kindDec;
  logic       err;
  logic       dErr;
  logic       need6Neg;
  logic       need6Pos;
  logic       rdStart;
  logic       rdMid;
  logic       rdOut;
  logic       rdPos;
  logic       rdKnown;   // Cleared until a good code seeds it

  always_comb
  begin
    wAll = revCode(rxCode);
    w6 = wAll[9:4];
    w4 = wAll[3:0];
    {ok6, x5} = dec6(w6);
    {ok4, y3} = dec4(w4);

    // Delimiters, either polarity
    isK = (w6 == 6'b001111) || (w6 == 6'b110000);
    kKnown = 1'b1;
    if ((wAll == `ELINK_K28_1) || (wAll == ~`ELINK_K28_1))
      kindDec = kindSop;
    else if ((wAll == `ELINK_K28_6) || (wAll == ~`ELINK_K28_6))
      kindDec = kindEop;
    else if ((wAll == `ELINK_K28_5) || (wAll == ~`ELINK_K28_5))
      kindDec = kindIdle;
    else
    begin
      kindDec = kindData;
      kKnown = !isK;   // Other K28.y not supported
    end
    err = !ok6 || !ok4 || !kKnown;

    // Disparity, each unbalanced block sets RD outright
    need6Neg = ($countones(w6) == 4) || (w6 == 6'b111000);
    need6Pos = ($countones(w6) == 2) || (w6 == 6'b000111);
    rdStart = rdKnown ? rdPos : (need6Pos ? 1'b1 : (need6Neg ? 1'b0 : rdPos));
    dErr = (need6Neg && rdStart) || (need6Pos && !rdStart);
    rdMid = ($countones(w6) != 3) ? ($countones(w6) > 3) : rdStart;
    if ((($countones(w4) == 3) || (w4 == 4'b1100)) && rdMid)
      dErr = 1'b1;
    if ((($countones(w4) == 1) || (w4 == 4'b0011)) && !rdMid)
      dErr = 1'b1;
    rdOut = ($countones(w4) != 2) ? ($countones(w4) > 2) : rdMid;
  end

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      rxValid <= 1'b0;
      codeErr <= 1'b0;
      dispErr <= 1'b0;
      rdPos <= 1'b0;   // Starts negative
      rdKnown <= 1'b0;
    end
    else
    begin
      rxValid <= codeStrobe;   // Every code, idles too
      if (codeStrobe)
      begin
        codeErr <= err;
        dispErr <= dErr && rdKnown && !err;
        rdPos <= rdOut;
        rdKnown <= !err;   // Reseed after a bad code
      end
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (codeStrobe)
    begin
      rxSym.kind <= err ? kindIdle : kindDec;   // Bad code never reads as payload
      rxSym.dataByte <= {y3, x5};
    end
  end

endmodule

`default_nettype wire

//--- elinkLoopback.sv
`timescale 1ns/1ps
`default_nettype none
`include "elink_params.svh"

module elinkLoopback
  import elinkPkg::*;
(
  input  wire logic                    getDataTrig,
  input  wire logic                    rstN,
  input  wire elinkSym_t               dataIn,
  input  wire logic                    dataRdy,
  input  wire logic                    swapBits,
  input  wire logic                    reverseOrder,
  output logic                         dataReq,
  output logic [`ELINK_LANE_W-1:0]     elinkOut,
  output elinkSym_t                    rxSym,
  output logic                         rxValid,
  output elinkRxStat_t                 rxStat
);

  elinkCode_t               txCode;
  logic [`ELINK_CODE_W-1:0] rxCode;
  logic                     codeStrobe;

  // Transmit side
  elinkEncoder8b10b uEncoder (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .symReq      (dataReq),
    .dataIn      (dataIn),
    .dataRdy     (dataRdy),
    .txCode      (txCode)
  );

  elinkTxSerializer uSerializer (
    .getDataTrig  (getDataTrig),
    .rstN         (rstN),
    .txCode       (txCode),
    .swapBits     (swapBits),
    .reverseOrder (reverseOrder),
    .symReq       (dataReq),   // Also the source request
    .elinkOut     (elinkOut)
  );

  // Receive side, fed from the lane
  elinkRxAligner uAligner (
    .getDataTrig  (getDataTrig),
    .rstN         (rstN),
    .elinkIn      (elinkOut),
    .swapBits     (swapBits),
    .reverseOrder (reverseOrder),
    .rxCode       (rxCode),
    .codeStrobe   (codeStrobe),
    .aligned      (rxStat.aligned),
    .realignHint  (rxStat.codeErr)
  );

  elinkDecoder8b10b uDecoder (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .rxCode      (rxCode),
    .codeStrobe  (codeStrobe),
    .rxSym       (rxSym),
    .rxValid     (rxValid),
    .codeErr     (rxStat.codeErr),
    .dispErr     (rxStat.dispErr)
  );

endmodule

`default_nettype wire

//--- elinkTbRef.svh
`ifndef ELINK_TB_REF_SVH
`define ELINK_TB_REF_SVH

// 5b/6b words at RD-, abcdei with a as MSB, index is EDCBA
localparam logic [0:31][5:0] sixNeg = {
  6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
  6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
  6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
  6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b words at RD-, fghj, primary D.x.7
localparam logic [0:7][3:0] fourNeg = {
  4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

function automatic logic [9:0] flipBits10(input logic [9:0] v);
  logic [9:0] r;
  for (int i = 0; i < 10; i++)
    r[i] = v[9 - i];
  return r;
endfunction

// Expected line code, a at bit 0, plus RD after it
function automatic elinkCode_t refEncode(input elinkSym_t sym, input logic rdIn);
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] six;
  logic [3:0] four;
  logic [9:0] word;   // abcdeifghj, a as MSB
  logic       rd6;
  elinkCode_t res;
  x = sym.dataByte[4:0];
  y = sym.dataByte[7:5];
  six = sixNeg[x];
  if (rdIn && (($countones(six) != 3) || (x == 5'd7)))
    six = ~six;   // RD+ form
  rd6 = ($countones(six) == 3) ? rdIn : ($countones(six) > 3);
  four = fourNeg[y];
  if ((y == 3'd7) && ((!rd6 && ((x == 5'd17) || (x == 5'd18) || (x == 5'd20))) ||
                      (rd6 && ((x == 5'd11) || (x == 5'd13) || (x == 5'd14)))))
    four = 4'b0111;   // A.7, no run of five
  if (rd6 && (($countones(four) != 2) || (y == 3'd3)))
    four = ~four;
  word = {six, four};
  if (sym.kind == kindSop)
    word = 10'b001111_1001;   // K28.1
  else if (sym.kind == kindEop)
    word = 10'b001111_0110;   // K28.6
  else if (sym.kind == kindIdle)
    word = 10'b001111_1010;   // K28.5
  if ((sym.kind != kindData) && rdIn)
    word = ~word;   // K codes at RD+ are complements
  res.code = flipBits10(word);
  res.rdPos = ($countones(word) == 5) ? rdIn : ($countones(word) > 5);
  return res;
endfunction

function automatic logic [31:0] lcgNext(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
  checkCount++;
  if (got !== exp)
  begin
    errCount++;
    $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
  end
endtask

`endif

//--- elinkLoopbackTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "elink_params.svh"

module elinkLoopbackTb
  import elinkPkg::*;
();

  logic                     getDataTrig;
  logic                     rstN;
  elinkSym_t                dataIn;
  logic                     dataRdy;
  logic                     swapBits;
  logic                     reverseOrder;
  logic                     dataReq;
  logic [`ELINK_LANE_W-1:0] elinkOut;
  elinkSym_t                rxSym;
  logic                     rxValid;
  elinkRxStat_t             rxStat;

  int                       errCount;
  int                       checkCount;
  int                       testCount;
  int                       errBase;
  int                       codeErrSeen;
  string                    curTest;
  logic [31:0]              lcgState;
  logic                     skipCode;       // Lane overridden for this code
  logic                     monRd;          // Expected encoder RD
  logic [`ELINK_CODE_W-1:0] laneAcc;
  elinkSym_t                txQ[$];         // Codes on the lane, oldest first
  elinkSym_t                rxQ[$];         // Non-idle symbols still owed by RX

  `include "elinkTbRef.svh"

  initial
  begin
    getDataTrig = 1'b0;
    forever
      #50 getDataTrig = ~getDataTrig;
  end

  elinkLoopback DUT (
    .getDataTrig  (getDataTrig),
    .rstN         (rstN),
    .dataIn       (dataIn),
    .dataRdy      (dataRdy),
    .swapBits     (swapBits),
    .reverseOrder (reverseOrder),
    .dataReq      (dataReq),
    .elinkOut     (elinkOut),
    .rxSym        (rxSym),
    .rxValid      (rxValid),
    .rxStat       (rxStat)
  );

  function automatic elinkSym_t mkSym(input symKind_t k, input logic [7:0] b);
    elinkSym_t s;
    s.kind = k;
    s.dataByte = b;
    return s;
  endfunction

  function automatic logic [15:0] randWord();
    lcgState = lcgNext(lcgState);
    return lcgState[31:16];   // High bits, better spread
  endfunction

  // Lane monitor, regroups pairs into codes ending on dataReq
  always @(posedge getDataTrig)
  begin : laneMonitor
    elinkSym_t                expSym;
    elinkCode_t               expCode;
    logic [`ELINK_CODE_W-1:0] got;
    logic                     firstBit;
    logic                     secondBit;
    if (!rstN)
    begin
      laneAcc = '0;
      monRd = 1'b0;   // RD- after reset
      txQ.delete();
      rxQ.delete();
      txQ.push_back(mkSym(kindIdle, 8'h00));   // Reset code is an idle
    end
    else
    begin
      firstBit = swapBits ? elinkOut[1] : elinkOut[0];
      secondBit = swapBits ? elinkOut[0] : elinkOut[1];
      laneAcc = {secondBit, firstBit, laneAcc[`ELINK_CODE_W-1:2]};   // First bit lands at 0
      if (dataReq)
      begin
        got = reverseOrder ? flipBits10(laneAcc) : laneAcc;
        expSym = txQ.pop_front();
        expCode = refEncode(expSym, monRd);
        monRd = expCode.rdPos;
        if (!skipCode)
          checkEq("elinkOut code", got, expCode.code);
        // Encoder takes the next symbol at this edge
        expSym = dataRdy ? dataIn : mkSym(kindIdle, 8'h00);
        txQ.push_back(expSym);
        if (expSym.kind != kindIdle)
          rxQ.push_back(expSym);
      end
    end
  end

  // Receive scoreboard
  always @(posedge getDataTrig)
  begin : rxScoreboard
    elinkSym_t expSym;
    if (rstN && rxValid)
    begin
      checkEq("rxStat.aligned", rxStat.aligned, 1'b1);
      checkEq("rxStat.dispErr", rxStat.dispErr, 1'b0);
      if (rxStat.codeErr)
        codeErrSeen++;
      else if (rxSym.kind != kindIdle)
      begin
        if (rxQ.size() == 0)
        begin
          errCount++;
          $display("extra symbol 0x%0h received at %0t ns with none outstanding", rxSym, $time);
        end
        else
        begin
          expSym = rxQ.pop_front();
          checkEq("rxSym.kind", rxSym.kind, expSym.kind);
          if (expSym.kind == kindData)
            checkEq("rxSym.dataByte", rxSym.dataByte, expSym.dataByte);
        end
      end
    end
  end

  task automatic abortRun(input string why);
    $display("timeout: %s at %0t ns", why, $time);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic applyReset(input logic swapSel, input logic revSel);
    @(negedge getDataTrig);
    rstN = 1'b0;
    dataRdy = 1'b0;
    swapBits = swapSel;
    reverseOrder = revSel;
    repeat (8) @(negedge getDataTrig);
    rstN = 1'b1;
  endtask

  // Also checks rxValid stays quiet before lock
  task automatic waitAligned(output int clocks);
    clocks = 0;
    while (!rxStat.aligned)
    begin
      @(negedge getDataTrig);
      clocks++;
      checkEq("rxValid before lock", rxValid, 1'b0);
      if (clocks > 200)
        abortRun("aligner did not lock within 200 clocks");
    end
  endtask

  task automatic waitReq();
    int n;
    n = 0;
    @(negedge getDataTrig);
    while (!dataReq)
    begin
      n++;
      if (n > 10)
        abortRun("dataReq missing for 10 clocks");
      @(negedge getDataTrig);
    end
  endtask

  // Random idle requests first when gaps are on
  task automatic offer(input elinkSym_t sym, input logic gaps);
    logic [15:0] w;
    w = randWord();
    if (gaps)
      repeat (w % 3)
      begin
        waitReq();
        dataRdy = 1'b0;
      end
    waitReq();
    dataIn = sym;
    dataRdy = 1'b1;
  endtask

  task automatic drainRx();
    int n;
    waitReq();
    dataRdy = 1'b0;
    n = 0;
    while (rxQ.size() != 0)
    begin
      @(negedge getDataTrig);
      n++;
      if (n > 200)
        abortRun("receive side still owes symbols after 200 clocks");
    end
  endtask

  task automatic roundTrip(input int packets, input logic gaps);
    logic [15:0] w;
    for (int p = 0; p < packets; p++)
    begin
      w = randWord();
      offer(mkSym(kindSop, w[15:8]), gaps);
      for (int i = 0; i <= w[2:0]; i++)   // One to eight bytes
        offer(mkSym(kindData, randWord()), gaps);
      offer(mkSym(kindEop, w[7:0]), gaps);
    end
    drainRx();
  endtask

  task automatic startTest(input string name);
    curTest = name;
    errBase = errCount;
    codeErrSeen = 0;
  endtask

  task automatic finishTest(input int codeErrExp);
    checkEq("codeErr count", codeErrSeen, codeErrExp);
    testCount++;
    $display("test %0d %s: %0d errors", testCount, curTest, errCount - errBase);
  endtask

  initial
  begin
    int          clocks;
    logic [15:0] w;
    rstN = 1'b0;
    dataIn = mkSym(kindIdle, 8'h00);
    dataRdy = 1'b0;
    swapBits = 1'b0;
    reverseOrder = 1'b0;
    skipCode = 1'b0;
    errCount = 0;
    checkCount = 0;
    testCount = 0;
    lcgState = 32'd32651;

    startTest("reset and lock");
    applyReset(1'b0, 1'b0);
    waitAligned(clocks);
    checkEq("lock clocks within 40", clocks <= 40, 1'b1);
    repeat (4) waitReq();   // A few more idles past lock
    finishTest(0);

    startTest("encoding of 300 random symbols");
    for (int i = 0; i < 300; i++)
    begin
      w = randWord();
      offer(mkSym(symKind_t'(w[9:8]), w[7:0]), 1'b0);
    end
    drainRx();
    finishTest(0);

    startTest("framed round trip");
    roundTrip(20, 1'b0);
    finishTest(0);

    startTest("round trip with gaps");
    roundTrip(20, 1'b1);
    finishTest(0);

    startTest("round trip with swapBits");
    applyReset(1'b1, 1'b0);
    waitAligned(clocks);
    roundTrip(15, 1'b1);
    finishTest(0);

    startTest("round trip with reverseOrder");
    applyReset(1'b0, 1'b1);
    waitAligned(clocks);
    roundTrip(15, 1'b1);
    finishTest(0);

    startTest("code error injection");
    applyReset(1'b0, 1'b0);
    waitAligned(clocks);
    roundTrip(2, 1'b0);
    waitReq();
    dataRdy = 1'b0;   // Idle goes out, then gets overwritten
    @(negedge getDataTrig);
    skipCode = 1'b1;
    force DUT.uAligner.elinkIn = 2'b00;   // Lane override in front of the aligner
    repeat (`ELINK_PAIRS) @(negedge getDataTrig);
    release DUT.uAligner.elinkIn;
    skipCode = 1'b0;
    roundTrip(5, 1'b0);
    checkEq("rxStat.aligned after error", rxStat.aligned, 1'b1);
    finishTest(1);

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    if (errCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- elinkLoopback.f
+incdir+.
elinkPkg.sv
elinkEncoder8b10b.sv
elinkTxSerializer.sv
elinkRxAligner.sv
elinkDecoder8b10b.sv
elinkLoopback.sv
elinkLoopbackTb.sv
